//--- frame_parser.sv
module frame_parser (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            rx_done_tick,
	input  logic [7:0]                      rx_data,
	output logic                            word_push,
	output logic [mcb_pkg::data_width-1:0]  word_data,
	output logic                            frame_done,
	output mcb_pkg::mcb_cmd_t               frame_cmd
);

	host_frame_pkg::frame_state_e state;
	host_frame_pkg::addr_word_u addr_word;
	logic [1:0] addr_cnt;
	logic [mcb_pkg::bl_width-1:0] frame_bl;
	logic [mcb_pkg::bl_width-1:0] data_cnt;
	logic len_ok;
	logic last_byte;

	// accepted lengths are 1 to max_frame_len
	assign len_ok = (rx_data != 8'd0) &&
		(rx_data <= 8'(host_frame_pkg::max_frame_len));

	// frame_bl is already length minus one
	assign last_byte = (state == host_frame_pkg::data) && (data_cnt == frame_bl);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= host_frame_pkg::idle;
			addr_cnt <= '0;
			data_cnt <= '0;
			word_push <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			// strobes last one cycle
			word_push <= 1'b0;
			frame_done <= 1'b0;
			if (rx_done_tick) begin
				case (state)
					host_frame_pkg::idle: begin
						// anything but the start byte is skipped
						if (rx_data == host_frame_pkg::start_byte) begin
							state <= host_frame_pkg::address;
							addr_cnt <= '0;
						end
					end
					host_frame_pkg::address: begin
						addr_cnt <= addr_cnt + 1'b1;
						if (addr_cnt == 2'd3) begin
							state <= host_frame_pkg::length;
						end
					end
					host_frame_pkg::length: begin
						data_cnt <= '0;
						// bad length drops the frame silently
						state <= len_ok ? host_frame_pkg::data : host_frame_pkg::idle;
					end
					host_frame_pkg::data: begin
						word_push <= 1'b1;
						data_cnt <= data_cnt + 1'b1;
						if (last_byte) begin
							frame_done <= 1'b1;
							state <= host_frame_pkg::idle;
						end
					end
					default: state <= host_frame_pkg::idle;
				endcase
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (rx_done_tick) begin
			if (state == host_frame_pkg::address) begin
				// msb arrives first, shift towards the top
				addr_word.bytes <= {addr_word.bytes[2:0], rx_data};
			end
			if (state == host_frame_pkg::length) begin
				frame_bl <= rx_data[mcb_pkg::bl_width-1:0] - 1'b1;
			end
			if (state == host_frame_pkg::data) begin
				word_data <= {{(mcb_pkg::data_width - 8){1'b0}}, rx_data};
			end
			if (last_byte) begin
				frame_cmd.instr <= mcb_pkg::instr_write;
				frame_cmd.bl <= frame_bl;
				frame_cmd.addr <= addr_word.fields.addr;
			end
		end
	end

endmodule

//--- host_frame_pkg.sv
package host_frame_pkg;

	// framing bytes exchanged with the host over the UART
	localparam logic [7:0] start_byte = 8'd255;
	localparam logic [7:0] done_byte = 8'd30;

	// largest data payload of one frame, in bytes
	localparam int max_frame_len = 64;

	// receive parser states
	typedef enum logic [1:0] {
		idle    = 2'b00,
		address = 2'b01,
		length  = 2'b10,
		data    = 2'b11
	} frame_state_e;

	// decoded view of the address word
	typedef struct packed {
		logic [1:0]  reserved;
		logic [29:0] addr;
	} addr_fields_t;

	// same word seen as the four received bytes (msb first) or as fields
	typedef union packed {
		logic [3:0][7:0] bytes;
		addr_fields_t    fields;
	} addr_word_u;

endpackage

//--- mcb_pkg.sv
package mcb_pkg;

	// user port widths
	localparam int addr_width = 30;
	localparam int data_width = 32;
	localparam int bl_width = 6;

	// command codes
	localparam logic [2:0] instr_write = 3'b000;

	// fifo depths on the host side of the port
	localparam int wfifo_depth = 64;
	localparam int rfifo_depth = 16;

	// one command on the command path
	// bl holds the burst length in words minus one
	typedef struct packed {
		logic [2:0]            instr;
		logic [bl_width-1:0]   bl;
		logic [addr_width-1:0] addr;
	} mcb_cmd_t;

endpackage

//--- mcb_write_port.sv
module mcb_write_port (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           fifo_empty,
	input  logic [mcb_pkg::data_width-1:0] fifo_head,
	output logic                           fifo_pop,
	input  logic                           frame_done,
	input  mcb_pkg::mcb_cmd_t              frame_cmd,
	input  logic                           wr_full,
	input  logic                           cmd_full,
	output logic                           wr_en,
	output logic [mcb_pkg::data_width-1:0] wr_data,
	output logic                           cmd_en,
	output mcb_pkg::mcb_cmd_t              cmd
);

	// slot 0 is always the oldest pending command
	logic [1:0] pend_valid;
	logic [1:0] valid_n;
	mcb_pkg::mcb_cmd_t [1:0] pend_cmd;
	mcb_pkg::mcb_cmd_t [1:0] cmd_n;
	logic [1:0][mcb_pkg::bl_width:0] pend_remain;
	logic [1:0][mcb_pkg::bl_width:0] remain_n;
	// words already written for the frame still being received
	logic [mcb_pkg::bl_width:0] loose;
	logic [mcb_pkg::bl_width:0] loose_n;
	logic [mcb_pkg::bl_width:0] new_remain;

	assign wr_en = !fifo_empty && !wr_full;
	assign fifo_pop = wr_en;
	assign wr_data = fifo_head;

	assign cmd_en = pend_valid[0] && (pend_remain[0] == '0) && !cmd_full;
	assign cmd = pend_cmd[0];

	always_comb begin
		valid_n = pend_valid;
		cmd_n = pend_cmd;
		remain_n = pend_remain;
		loose_n = loose;
		new_remain = '0;

		// each written word belongs to the oldest frame still owing words
		if (wr_en) begin
			if (pend_valid[0] && (pend_remain[0] != '0)) begin
				remain_n[0] = pend_remain[0] - 1'b1;
			end else if (pend_valid[1] && (pend_remain[1] != '0)) begin
				remain_n[1] = pend_remain[1] - 1'b1;
			end else begin
				loose_n = loose + 1'b1;
			end
		end

		// retire the issued command, move the younger one up
		if (cmd_en) begin
			valid_n[0] = valid_n[1];
			cmd_n[0] = cmd_n[1];
			remain_n[0] = remain_n[1];
			valid_n[1] = 1'b0;
		end

		// words of this frame not yet written
		if (frame_done) begin
			new_remain = {1'b0, frame_cmd.bl} + 1'b1 - loose_n;
			loose_n = '0;
			if (!valid_n[0]) begin
				valid_n[0] = 1'b1;
				cmd_n[0] = frame_cmd;
				remain_n[0] = new_remain;
			end else begin
				valid_n[1] = 1'b1;
				cmd_n[1] = frame_cmd;
				remain_n[1] = new_remain;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pend_valid <= '0;
			loose <= '0;
		end else begin
			pend_valid <= valid_n;
			loose <= loose_n;
		end
	end

	always_ff @(posedge clk) begin
		pend_cmd <= cmd_n;
		pend_remain <= remain_n;
	end

endmodule

//--- reply_sender.sv
module reply_sender (
	input  logic       clk,
	input  logic       reset,
	input  logic       fifo_empty,
	input  logic [7:0] fifo_head,
	output logic       fifo_pop,
	input  logic       tx_busy,
	output logic       tx_start,
	output logic [7:0] tx_data
);

	// start issued in the previous cycle
	logic start_q;

	// the transmitter raises tx_busy one cycle after a start,
	// so a start right after another one is held back
	assign tx_start = !fifo_empty && !tx_busy && !start_q;

	// byte leaves the fifo as the transmitter takes it
	assign fifo_pop = tx_start;
	assign tx_data = fifo_head;

	always_ff @(posedge clk) begin
		if (reset) begin
			start_q <= 1'b0;
		end else begin
			start_q <= tx_start;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the traffic generator testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module traffic_generator_tb -f traffic_generator.f -o sim_tb; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi

echo "simulation did not report success"
exit 1

//--- sync_fifo.sv
module sync_fifo #(
	parameter int width = 8,
	parameter int depth = 16
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic             pop,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout,
	output logic             full,
	output logic             empty
);

	localparam int ptr_width = $clog2(depth);
	localparam int count_width = $clog2(depth + 1);
	localparam logic [ptr_width-1:0] last_slot = ptr_width'(depth - 1);
	localparam logic [count_width-1:0] full_count = count_width'(depth);

	logic [width-1:0] mem [depth];
	logic [ptr_width-1:0] rd_ptr;
	logic [ptr_width-1:0] wr_ptr;
	logic [count_width-1:0] count;
	logic do_push;
	logic do_pop;

	// push on full and pop on empty are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == full_count);
	assign empty = (count == '0);

	// head word shows through while not empty
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
	parameter int half_period = 50,
	parameter int reset_cycles = 5,
	parameter int release_delay = 10
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// released just after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#release_delay;
		reset = 1'b0;
	end

endmodule

//--- traffic_generator.f
host_frame_pkg.sv
mcb_pkg.sv
sync_fifo.sv
frame_parser.sv
mcb_write_port.sv
reply_sender.sv
traffic_generator.sv
tb_clock_gen.sv
traffic_generator_properties.sv
traffic_generator_tb.sv

//--- traffic_generator.sv
module traffic_generator (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           rx_done_tick,
	input  logic [7:0]                     rx_data,
	output logic                           tx_start,
	output logic [7:0]                     tx_data,
	input  logic                           tx_busy,
	output logic                           cmd_en,
	output logic [2:0]                     cmd_instr,
	output logic [mcb_pkg::bl_width-1:0]   cmd_bl,
	output logic [mcb_pkg::addr_width-1:0] cmd_addr,
	input  logic                           cmd_full,
	output logic                           wr_en,
	output logic [mcb_pkg::data_width-1:0] wr_data,
	input  logic                           wr_full
);

	// parser to write fifo
	logic word_push;
	logic [mcb_pkg::data_width-1:0] word_data;

	// write fifo to mcb port
	logic word_pop;
	logic word_empty;
	logic [mcb_pkg::data_width-1:0] word_head;

	// end of frame, also queues the done byte
	logic frame_done;
	mcb_pkg::mcb_cmd_t frame_cmd;
	mcb_pkg::mcb_cmd_t cmd;

	// reply fifo to transmitter
	logic reply_pop;
	logic reply_empty;
	logic [7:0] reply_head;

	assign cmd_instr = cmd.instr;
	assign cmd_bl = cmd.bl;
	assign cmd_addr = cmd.addr;

	frame_parser parser (
		.clk         (clk),
		.reset       (reset),
		.rx_done_tick(rx_done_tick),
		.rx_data     (rx_data),
		.word_push   (word_push),
		.word_data   (word_data),
		.frame_done  (frame_done),
		.frame_cmd   (frame_cmd)
	);

	sync_fifo #(
		.width(mcb_pkg::data_width),
		.depth(mcb_pkg::wfifo_depth)
	) word_fifo (
		.clk  (clk),
		.reset(reset),
		.push (word_push),
		.pop  (word_pop),
		.din  (word_data),
		.dout (word_head),
		.full (),
		.empty(word_empty)
	);

	mcb_write_port write_port (
		.clk       (clk),
		.reset     (reset),
		.fifo_empty(word_empty),
		.fifo_head (word_head),
		.fifo_pop  (word_pop),
		.frame_done(frame_done),
		.frame_cmd (frame_cmd),
		.wr_full   (wr_full),
		.cmd_full  (cmd_full),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.cmd_en    (cmd_en),
		.cmd       (cmd)
	);

	sync_fifo #(
		.width(8),
		.depth(mcb_pkg::rfifo_depth)
	) reply_fifo (
		.clk  (clk),
		.reset(reset),
		.push (frame_done),
		.pop  (reply_pop),
		.din  (host_frame_pkg::done_byte),
		.dout (reply_head),
		.full (),
		.empty(reply_empty)
	);

	reply_sender sender (
		.clk       (clk),
		.reset     (reset),
		.fifo_empty(reply_empty),
		.fifo_head (reply_head),
		.fifo_pop  (reply_pop),
		.tx_busy   (tx_busy),
		.tx_start  (tx_start),
		.tx_data   (tx_data)
	);

endmodule

//--- traffic_generator_properties.sv
module traffic_generator_properties (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic wr_full,
	input logic cmd_en,
	input logic cmd_full,
	input logic tx_start
);
	timeunit 1ns;
	timeprecision 1ps;

	// write datapath back-pressure
	wr_en_held_off: assert property (@(posedge clk) disable iff (reset)
		!(wr_en && wr_full))
		else $error("wr_en high while wr_full is high");

	// command path back-pressure
	cmd_en_held_off: assert property (@(posedge clk) disable iff (reset)
		!(cmd_en && cmd_full))
		else $error("cmd_en high while cmd_full is high");

	// one start per transmitted byte
	tx_start_single: assert property (@(posedge clk) disable iff (reset)
		tx_start |=> !tx_start)
		else $error("tx_start high in two consecutive cycles");

endmodule

bind traffic_generator traffic_generator_properties props (
	.clk     (clk),
	.reset   (reset),
	.wr_en   (wr_en),
	.wr_full (wr_full),
	.cmd_en  (cmd_en),
	.cmd_full(cmd_full),
	.tx_start(tx_start)
);

//--- traffic_generator_tb.sv
module traffic_generator_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int drive_delay = 10;
	localparam int model_delay = 20;
	localparam int settle_cycles = 30;
	localparam int trailing_bytes = 4;
	localparam logic [2:0] write_code = 3'b000;
	localparam logic [7:0] expected_reply = 8'd30;
	localparam int n_rows = 10;

	typedef struct packed {
		logic [31:0] addr;
		logic [7:0]  len;
		logic [7:0]  seed;
		logic [1:0]  junk;
		logic        bp;
	} frame_row_t;

	// address, length, data seed, junk bytes before the start byte, back-pressure
	localparam frame_row_t rows [n_rows] = '{
		'{32'h0000_1000, 8'd4,  8'h11, 2'd0, 1'b0},
		'{32'hc000_0040, 8'd1,  8'hf0, 2'd0, 1'b0},
		'{32'h1234_5678, 8'd64, 8'h00, 2'd0, 1'b0},
		'{32'h0000_2000, 8'd0,  8'h22, 2'd0, 1'b0},
		'{32'h0000_3000, 8'd8,  8'h33, 2'd3, 1'b0},
		'{32'h0000_4000, 8'd65, 8'h44, 2'd0, 1'b0},
		'{32'hffff_ffff, 8'd16, 8'hf8, 2'd2, 1'b0},
		'{32'h0abc_def0, 8'd32, 8'h55, 2'd0, 1'b1},
		'{32'h8000_0004, 8'd64, 8'h66, 2'd0, 1'b1},
		'{32'h0000_0100, 8'd3,  8'h77, 2'd1, 1'b1}
	};

	logic clk;
	logic reset;
	logic rx_done_tick;
	logic [7:0] rx_data;
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_busy = 1'b0;
	logic cmd_en;
	logic [2:0] cmd_instr;
	logic [5:0] cmd_bl;
	logic [29:0] cmd_addr;
	logic cmd_full = 1'b0;
	logic wr_en;
	logic [31:0] wr_data;
	logic wr_full = 1'b0;

	int seed = 69180;
	int errors = 0;
	int monitor_errors = 0;
	int cycle_count = 0;
	int cycle_limit;
	int last_wr_cycle = 0;
	int cmd_cycle = 0;
	int starts_taken = 0;
	int starts_served = 0;
	int uart_count = 0;
	int word_base;
	int cmd_base;
	int reply_base;
	logic bp_on = 1'b0;

	// everything seen on the MCB and UART side
	logic [31:0] got_words [$];
	mcb_pkg::mcb_cmd_t got_cmds [$];
	logic [7:0] got_replies [$];

	tb_clock_gen #(
		.half_period (50),
		.reset_cycles(5)
	) clock_gen (
		.clk  (clk),
		.reset(reset)
	);

	traffic_generator dut0 (
		.clk         (clk),
		.reset       (reset),
		.rx_done_tick(rx_done_tick),
		.rx_data     (rx_data),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.tx_busy     (tx_busy),
		.cmd_en      (cmd_en),
		.cmd_instr   (cmd_instr),
		.cmd_bl      (cmd_bl),
		.cmd_addr    (cmd_addr),
		.cmd_full    (cmd_full),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.wr_full     (wr_full)
	);

	// data byte i of a frame
	function automatic logic [7:0] payload_byte(input frame_row_t row, input int i);
		return 8'(int'(row.seed) + i * 7);
	endfunction

	function automatic bit length_ok(input frame_row_t row);
		return (row.len >= 8'd1) && (row.len <= 8'd64);
	endfunction

	// bytes after the length byte, a few noise bytes follow a rejected length
	function automatic int payload_count(input frame_row_t row);
		int count;
		if (length_ok(row)) begin
			count = int'(row.len);
		end else begin
			count = trailing_bytes;
		end
		return count;
	endfunction

	// at most three cycles per byte, plus room to drain each frame
	function automatic int run_limit();
		int limit;
		limit = 200;
		for (int r = 0; r < n_rows; r++) begin
			limit += (int'(rows[r].junk) + 6 + payload_count(rows[r])) * 3 + 300;
		end
		return limit;
	endfunction

	// one rx_done_tick, then a random idle gap
	task automatic send_byte(input logic [7:0] value);
		int gap;
		rx_done_tick = 1'b1;
		rx_data = value;
		@(posedge clk);
		#drive_delay;
		rx_done_tick = 1'b0;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) begin
			@(posedge clk);
			#drive_delay;
		end
	endtask

	task automatic send_frame(input frame_row_t row);
		for (int k = 0; k < int'(row.junk); k++) begin
			send_byte(8'(8'h10 + k));
		end
		send_byte(8'd255);
		send_byte(row.addr[31:24]);
		send_byte(row.addr[23:16]);
		send_byte(row.addr[15:8]);
		send_byte(row.addr[7:0]);
		send_byte(row.len);
		for (int i = 0; i < payload_count(row); i++) begin
			send_byte(payload_byte(row, i));
		end
	endtask

	task automatic check_valid(input int r, input frame_row_t row);
		int n;
		int new_words;
		n = int'(row.len);
		// the command and the done byte close the frame
		while (got_cmds.size() == cmd_base || got_replies.size() == reply_base) begin
			@(negedge clk);
		end
		new_words = got_words.size() - word_base;
		if (new_words != n) begin
			$display("error at %0t: frame %0d wrote %0d words, expected %0d", $time, r,
				new_words, n);
			errors++;
		end
		for (int i = 0; i < n; i++) begin
			if (i < new_words && got_words[word_base + i] != {24'h000000, payload_byte(row, i)}) begin
				$display("error at %0t: frame %0d word %0d is %h, expected %h", $time, r, i,
					got_words[word_base + i], {24'h000000, payload_byte(row, i)});
				errors++;
			end
		end
		if (got_cmds.size() - cmd_base != 1) begin
			$display("error at %0t: frame %0d gave %0d commands", $time, r,
				got_cmds.size() - cmd_base);
			errors++;
		end else begin
			if (got_cmds[cmd_base].instr != write_code) begin
				$display("error at %0t: frame %0d instr %b", $time, r, got_cmds[cmd_base].instr);
				errors++;
			end
			if (got_cmds[cmd_base].bl != 6'(n - 1)) begin
				$display("error at %0t: frame %0d bl %0d, expected %0d", $time, r,
					got_cmds[cmd_base].bl, n - 1);
				errors++;
			end
			if (got_cmds[cmd_base].addr != row.addr[29:0]) begin
				$display("error at %0t: frame %0d addr %h, expected %h", $time, r,
					got_cmds[cmd_base].addr, row.addr[29:0]);
				errors++;
			end
			if (cmd_cycle <= last_wr_cycle) begin
				$display("error at %0t: frame %0d command came before its last word", $time, r);
				errors++;
			end
		end
		if (got_replies.size() - reply_base != 1 || got_replies[reply_base] != expected_reply) begin
			$display("error at %0t: frame %0d reply is %h, expected one byte %h", $time, r,
				got_replies[reply_base], expected_reply);
			errors++;
		end
	endtask

	task automatic check_dropped(input int r);
		repeat (settle_cycles) @(negedge clk);
		if (got_words.size() != word_base || got_cmds.size() != cmd_base ||
			got_replies.size() != reply_base) begin
			$display("error at %0t: dropped frame %0d still produced output", $time, r);
			errors++;
		end
	endtask

	// MCB and UART monitor sampled mid-cycle
	always @(negedge clk) begin
		mcb_pkg::mcb_cmd_t seen;
		if (!reset) begin
			if (wr_en) begin
				got_words.push_back(wr_data);
				last_wr_cycle = cycle_count;
			end
			if (cmd_en) begin
				seen.instr = cmd_instr;
				seen.bl = cmd_bl;
				seen.addr = cmd_addr;
				got_cmds.push_back(seen);
				cmd_cycle = cycle_count;
			end
			if (tx_start) begin
				if (tx_busy) begin
					$display("error at %0t: tx_start while tx_busy is high", $time);
					monitor_errors++;
				end
				got_replies.push_back(tx_data);
				starts_taken++;
			end
		end
	end

	// uart busy after each start, fixed stretches of back-pressure
	always @(posedge clk) begin
		#model_delay;
		if (starts_taken != starts_served) begin
			starts_served = starts_taken;
			uart_count = 4;
		end else if (uart_count > 0) begin
			uart_count--;
		end
		wr_full = bp_on && ((cycle_count % 13) < 4);
		cmd_full = bp_on && ((cycle_count % 17) < 6);
		tx_busy = (uart_count > 0) || (bp_on && ((cycle_count % 23) < 7));
	end

	initial begin
		cycle_limit = run_limit();
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		int frame_errors;
		int expected_words;
		int expected_frames;
		int total_errors;
		rx_done_tick = 1'b0;
		rx_data = 8'h00;
		expected_words = 0;
		expected_frames = 0;
		@(negedge reset);
		for (int r = 0; r < n_rows; r++) begin
			frame_errors = errors + monitor_errors;
			word_base = got_words.size();
			cmd_base = got_cmds.size();
			reply_base = got_replies.size();
			bp_on = rows[r].bp;
			@(posedge clk);
			#drive_delay;
			send_frame(rows[r]);
			if (length_ok(rows[r])) begin
				check_valid(r, rows[r]);
				expected_words += int'(rows[r].len);
				expected_frames++;
			end else begin
				check_dropped(r);
			end
			bp_on = 1'b0;
			$display("frame %0d: addr %h length %0d %s", r, rows[r].addr, rows[r].len,
				(errors + monitor_errors == frame_errors) ? "ok" : "failed");
		end
		// totals across all frames
		if (got_words.size() != expected_words || got_cmds.size() != expected_frames ||
			got_replies.size() != expected_frames) begin
			$display("error at %0t: totals differ from %0d words and %0d frames", $time,
				expected_words, expected_frames);
			errors++;
		end
		total_errors = errors + monitor_errors;
		$display("totals: %0d words, %0d commands, %0d replies, %0d errors",
			got_words.size(), got_cmds.size(), got_replies.size(), total_errors);
		if (total_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
